// ==== Bender.yml ====
package:
  name: singleCycleMips

sources:
  - mipsPkg.sv
  - pcUnit.sv
  - controlDecode.sv
  - regFile.sv
  - aluUnit.sv
  - memWriteback.sv
  - singleCycleMips.sv
  - target: test
    files:
      - mipsCore_asserts.sv
      - tbSingleCycleMips.sv

// ==== aluUnit.sv ====
//==========================================================================
// slt is signed; zero flag reflects any operation result
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module aluUnit
  import mipsPkg::*;
(
  input  word_t  rsData,
  input  word_t  rtData,
  input  imm_t   imm,
  input  wire    aluSrc,
  input  aluOp_t aluOp,
  output word_t  aluResult,
  output logic   zero
);

  word_t immExt;
  word_t opB;

  // sign extend for lw/sw offsets
  assign immExt = {{16{imm[15]}}, imm};
  // second operand, register or immediate
  assign opB = aluSrc ? immExt : rtData;

  always_comb begin
    case (aluOp)
      ALU_AND: aluResult = rsData & opB;
      ALU_OR:  aluResult = rsData | opB;
      ALU_ADD: aluResult = rsData + opB;
      ALU_SUB: aluResult = rsData - opB;
      // two's complement compare
      ALU_SLT: aluResult = {31'd0, $signed(rsData) < $signed(opB)};
      default: aluResult = '0;
    endcase
  end

  // used by beq
  assign zero = (aluResult == '0);

endmodule

`default_nettype wire

// ==== controlDecode.sv ====
//==========================================================================
// unknown opcode or function code decodes as a no-op
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module controlDecode
  import mipsPkg::*;
(
  input  word_t  instr,
  output logic   regDst,
  output logic   aluSrc,
  output logic   memToReg,
  output logic   regWrite,
  output logic   memWrite,
  output logic   memAccess,
  output logic   branch,
  output logic   jump,
  output logic   link,
  output logic   regJump,
  output aluOp_t aluOp
);

  opcode_t opcode;
  funct_t  funct;
  aluOp_t  fnOp;
  logic    fnWrite;
  logic    fnJr;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  //========================================================================
  // r-type function decode
  //========================================================================
  always_comb begin
    fnOp    = ALU_NONE;
    fnWrite = 1'b0;
    fnJr    = 1'b0;
    case (funct)
      FN_ADD: begin
        fnOp    = ALU_ADD;
        fnWrite = 1'b1;
      end
      FN_SUB: begin
        fnOp    = ALU_SUB;
        fnWrite = 1'b1;
      end
      FN_AND: begin
        fnOp    = ALU_AND;
        fnWrite = 1'b1;
      end
      FN_OR: begin
        fnOp    = ALU_OR;
        fnWrite = 1'b1;
      end
      FN_SLT: begin
        fnOp    = ALU_SLT;
        fnWrite = 1'b1;
      end
      // jr writes nothing, alu idle
      FN_JR: fnJr = 1'b1;
      default: fnOp = ALU_NONE;
    endcase
  end

  //========================================================================
  // main control
  //========================================================================
  always_comb begin
    // defaults give a no-op
    regDst    = 1'b0;
    aluSrc    = 1'b0;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memAccess = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    link      = 1'b0;
    regJump   = 1'b0;
    aluOp     = ALU_NONE;
    case (opcode)
      OP_RTYPE: begin
        regDst   = 1'b1;
        regWrite = fnWrite;
        regJump  = fnJr;
        aluOp    = fnOp;
      end
      OP_LW: begin
        // base plus offset
        aluSrc    = 1'b1;
        memToReg  = 1'b1;
        regWrite  = 1'b1;
        memAccess = 1'b1;
        aluOp     = ALU_ADD;
      end
      OP_SW: begin
        aluSrc    = 1'b1;
        memWrite  = 1'b1;
        memAccess = 1'b1;
        aluOp     = ALU_ADD;
      end
      OP_BEQ: begin
        // equality through zero flag
        branch = 1'b1;
        aluOp  = ALU_SUB;
      end
      OP_J: jump = 1'b1;
      OP_JAL: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: aluOp = ALU_NONE;
    endcase
  end

endmodule

`default_nettype wire

// ==== files.f ====
mipsPkg.sv
pcUnit.sv
controlDecode.sv
regFile.sv
aluUnit.sv
memWriteback.sv
singleCycleMips.sv
mipsCore_asserts.sv
tbSingleCycleMips.sv

// ==== memWriteback.sv ====
//==========================================================================
// active-low strobes; memory read data expected in the same cycle
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module memWriteback
  import mipsPkg::*;
(
  input  wire      memAccess,
  input  wire      memWrite,
  input  wire      memToReg,
  input  wire      regDst,
  input  wire      link,
  input  word_t    aluResult,
  input  word_t    rtData,
  input  word_t    memRdata,
  input  word_t    pcPlus4,
  input  regAddr_t rtAddr,
  input  regAddr_t rdAddr,
  output logic     cen,
  output logic     wen,
  output logic     oen,
  output memAddr_t memAddr,
  output word_t    memWdata,
  output regAddr_t wrAddr,
  output word_t    wrData
);

  // chip enable for lw and sw only
  assign cen = ~memAccess;
  assign wen = ~(memAccess & memWrite);
  // output enable only on reads
  assign oen = ~(memAccess & ~memWrite);

  // byte address to word address
  assign memAddr  = aluResult[8:2];
  assign memWdata = rtData;

  // write-back data, jal first
  assign wrData = link ? pcPlus4 : (memToReg ? memRdata : aluResult);
  // destination register
  assign wrAddr = link ? LINK_REG : (regDst ? rdAddr : rtAddr);

endmodule

`default_nettype wire

// ==== mipsCore_asserts.sv ====
//==========================================================================
// bound into singleCycleMips; sampled on the rising clock edge
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module mipsCore_asserts
  import mipsPkg::*;
(
  input wire   clk,
  input wire   rst,
  input word_t instrAddr,
  input wire   cen,
  input wire   wen,
  input wire   oen
);

  // failed assertions so far
  int assertFails = 0;

  // write only inside a chip access
  wenNeedsCen: assert property (@(posedge clk) disable iff (!rst) !wen |-> !cen)
    else begin
      $error("wen low while cen high");
      assertFails++;
    end

  // read and write never together
  noReadWrite: assert property (@(posedge clk) disable iff (!rst) !(!oen && !wen))
    else begin
      $error("oen and wen both low");
      assertFails++;
    end

  pcAligned: assert property (@(posedge clk) disable iff (!rst) instrAddr[1:0] == 2'b00)
    else begin
      $error("instrAddr not word aligned");
      assertFails++;
    end

  // first fetch after release
  pcAfterReset: assert property (@(posedge clk) $rose(rst) |-> instrAddr == RESET_PC)
    else begin
      $error("instrAddr not at reset address after reset");
      assertFails++;
    end

endmodule

bind singleCycleMips mipsCore_asserts uAsserts (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .cen       (cen),
  .wen       (wen),
  .oen       (oen)
);

`default_nettype wire

// ==== mipsPkg.sv ====
//==========================================================================
// MIPS32 subset only: word-addressed data memory, no immediate arithmetic
//==========================================================================
`default_nettype none

package mipsPkg;

  // basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  // data memory word address, aluResult[8:2]
  typedef logic [6:0]  memAddr_t;
  typedef logic [3:0]  aluOp_t;

  // instruction fields
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;
  typedef logic [25:0] target_t;

  //========================================================================
  // alu operation codes
  //========================================================================
  localparam aluOp_t ALU_AND  = 4'b0000;
  localparam aluOp_t ALU_OR   = 4'b0001;
  localparam aluOp_t ALU_ADD  = 4'b0010;
  localparam aluOp_t ALU_SUB  = 4'b0110;
  localparam aluOp_t ALU_SLT  = 4'b0111;
  // result forced to zero
  localparam aluOp_t ALU_NONE = 4'b1111;

  //========================================================================
  // opcodes and function codes
  //========================================================================
  localparam opcode_t OP_RTYPE = 6'b000000;
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_SW    = 6'b101011;
  localparam opcode_t OP_BEQ   = 6'b000100;
  localparam opcode_t OP_J     = 6'b000010;
  localparam opcode_t OP_JAL   = 6'b000011;

  localparam funct_t FN_ADD = 6'b100000;
  localparam funct_t FN_SUB = 6'b100010;
  localparam funct_t FN_AND = 6'b100100;
  localparam funct_t FN_OR  = 6'b100101;
  localparam funct_t FN_SLT = 6'b101010;
  localparam funct_t FN_JR  = 6'b001000;

  // jal return address register
  localparam regAddr_t LINK_REG = 5'd31;
  localparam word_t    RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== pcUnit.sv ====
//==========================================================================
// no delay slot; jump beats taken branch, which beats jr
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module pcUnit
  import mipsPkg::*;
(
  input  wire     clk,
  input  wire     rst,
  input  wire     branch,
  input  wire     zero,
  input  wire     jump,
  input  wire     regJump,
  input  imm_t    imm,
  input  target_t target,
  input  word_t   rsData,
  output word_t   pc,
  output word_t   pcPlus4
);

  word_t branchOffset;
  word_t branchTarget;
  word_t jumpTarget;
  logic  branchTaken;

  // sequential address
  assign pcPlus4 = pc + 32'd4;

  // sign extend then scale to bytes
  assign branchOffset = {{14{imm[15]}}, imm, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;
  // region bits kept from pc+4
  assign jumpTarget   = {pcPlus4[31:28], target, 2'b00};
  // beq taken only on equal operands
  assign branchTaken  = branch & zero;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= RESET_PC;
    end else if (jump) begin
      pc <= jumpTarget;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else if (regJump) begin
      // jr target taken as is
      pc <= rsData;
    end else begin
      pc <= pcPlus4;
    end
  end

endmodule

`default_nettype wire

// ==== regFile.sv ====
//==========================================================================
// register zero reads as zero, writes to it are dropped
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module regFile
  import mipsPkg::*;
(
  input  wire      clk,
  input  wire      rst,
  input  wire      regWrite,
  input  regAddr_t rsAddr,
  input  regAddr_t rtAddr,
  input  regAddr_t wrAddr,
  input  word_t    wrData,
  output word_t    rsData,
  output word_t    rtData
);

  // no storage behind register zero
  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // combinational read ports
  // no bypass, a write shows after the edge
  assign rsData = (rsAddr == 5'd0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

// ==== singleCycleMips.sv ====
//==========================================================================
// instr must be valid combinationally from instrAddr; one instruction/cycle
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module singleCycleMips
  import mipsPkg::*;
(
  input  wire      clk,
  input  wire      rst,
  output word_t    instrAddr,
  input  word_t    instr,
  input  word_t    memRdata,
  output word_t    memWdata,
  output memAddr_t memAddr,
  output logic     cen,
  output logic     wen,
  output logic     oen,
  output word_t    regWriteData
);

  //========================================================================
  // instruction fields
  //========================================================================
  regAddr_t rsAddr;
  regAddr_t rtAddr;
  regAddr_t rdAddr;
  imm_t     imm;
  target_t  target;

  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  assign rdAddr = instr[15:11];
  assign imm    = instr[15:0];
  assign target = instr[25:0];

  // control levels
  logic   regDst;
  logic   aluSrc;
  logic   memToReg;
  logic   regWrite;
  logic   memWrite;
  logic   memAccess;
  logic   branch;
  logic   jump;
  logic   link;
  logic   regJump;
  aluOp_t aluOp;

  // datapath
  word_t    pc;
  word_t    pcPlus4;
  word_t    rsData;
  word_t    rtData;
  word_t    aluResult;
  logic     zero;
  regAddr_t wrAddr;
  word_t    wrData;

  assign instrAddr    = pc;
  // observation port
  assign regWriteData = wrData;

  //========================================================================
  // blocks
  //========================================================================
  pcUnit uPc (
    .clk     (clk),
    .rst     (rst),
    .branch  (branch),
    .zero    (zero),
    .jump    (jump),
    .regJump (regJump),
    .imm     (imm),
    .target  (target),
    .rsData  (rsData),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  controlDecode uDecode (
    .instr     (instr),
    .regDst    (regDst),
    .aluSrc    (aluSrc),
    .memToReg  (memToReg),
    .regWrite  (regWrite),
    .memWrite  (memWrite),
    .memAccess (memAccess),
    .branch    (branch),
    .jump      (jump),
    .link      (link),
    .regJump   (regJump),
    .aluOp     (aluOp)
  );

  regFile uRegs (
    .clk      (clk),
    .rst      (rst),
    .regWrite (regWrite),
    .rsAddr   (rsAddr),
    .rtAddr   (rtAddr),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .rsData   (rsData),
    .rtData   (rtData)
  );

  aluUnit uAlu (
    .rsData    (rsData),
    .rtData    (rtData),
    .imm       (imm),
    .aluSrc    (aluSrc),
    .aluOp     (aluOp),
    .aluResult (aluResult),
    .zero      (zero)
  );

  // memory strobes and write-back select
  memWriteback uMemWb (
    .memAccess (memAccess),
    .memWrite  (memWrite),
    .memToReg  (memToReg),
    .regDst    (regDst),
    .link      (link),
    .aluResult (aluResult),
    .rtData    (rtData),
    .memRdata  (memRdata),
    .pcPlus4   (pcPlus4),
    .rtAddr    (rtAddr),
    .rdAddr    (rdAddr),
    .cen       (cen),
    .wen       (wen),
    .oen       (oen),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .wrAddr    (wrAddr),
    .wrData    (wrData)
  );

endmodule

`default_nettype wire

// ==== tbSingleCycleMips.sv ====
//==========================================================================
// programs sit at address 0 in a 64-word ROM; data memory is 128 words
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tbSingleCycleMips
  import mipsPkg::*;
();

  localparam int RESET_CYCLES = 16;
  // about fifteen times the reset and program cycles of all tests
  localparam int CYCLE_LIMIT  = 2000;

  logic     clk;
  logic     rst;
  word_t    instrAddr;
  word_t    instr;
  word_t    memRdata;
  word_t    memWdata;
  memAddr_t memAddr;
  logic     cen;
  logic     wen;
  logic     oen;
  word_t    regWriteData;

  word_t imem [0:63];
  word_t dmem [0:127];

  // architectural model state
  word_t mPc;
  word_t mRegs [0:31];
  word_t mMem  [0:127];

  int          errCount  = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          execCount = 0;
  int          cycles    = 0;
  logic        running   = 1'b0;
  logic [31:0] lfsrState = 32'hb13c4f74;

  singleCycleMips DUT (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .memRdata     (memRdata),
    .memWdata     (memWdata),
    .memAddr      (memAddr),
    .cen          (cen),
    .wen          (wen),
    .oen          (oen),
    .regWriteData (regWriteData)
  );

  //========================================================================
  // memory models
  //========================================================================
  // no-op while reset is held
  assign instr    = rst ? imem[instrAddr[7:2]] : 32'h0;
  assign memRdata = (!cen && !oen) ? dmem[memAddr] : 32'h0;

  always @(posedge clk) begin
    if (!cen && !wen) begin
      dmem[memAddr] <= memWdata;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //========================================================================
  // encoders and LFSR
  //========================================================================
  function automatic word_t rType(input regAddr_t rd, input regAddr_t rs,
                                  input regAddr_t rt, input funct_t fn);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t iType(input opcode_t op, input regAddr_t rs,
                                  input regAddr_t rt, input int off);
    return {op, rs, rt, off[15:0]};
  endfunction

  // target given as byte address
  function automatic word_t jType(input opcode_t op, input int byteAddr);
    return {op, byteAddr[27:2]};
  endfunction

  // taps 32,22,2,1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic fillDataMem;
    word_t w;
    for (int i = 0; i < 128; i++) begin
      w = '0;
      // one step per bit
      for (int b = 0; b < 32; b++) begin
        lfsrState = lfsrStep(lfsrState);
        w = {w[30:0], lfsrState[0]};
      end
      dmem[i] = w;
      mMem[i] = w;
    end
  endtask

  //========================================================================
  // reference model stepping one instruction per call
  //========================================================================
  function automatic logic refStep(input word_t ins, output word_t nextPc,
                                   output word_t wrVal);
    word_t    a;
    word_t    b;
    word_t    sImm;
    word_t    seq;
    word_t    ea;
    regAddr_t dst;
    logic     wr;
    a      = mRegs[ins[25:21]];
    b      = mRegs[ins[20:16]];
    sImm   = {{16{ins[15]}}, ins[15:0]};
    seq    = mPc + 32'd4;
    ea     = a + sImm;
    nextPc = seq;
    wrVal  = '0;
    wr     = 1'b0;
    dst    = ins[15:11];
    case (ins[31:26])
      OP_RTYPE: begin
        wr = 1'b1;
        case (ins[5:0])
          FN_ADD: wrVal = a + b;
          FN_SUB: wrVal = a - b;
          FN_AND: wrVal = a & b;
          FN_OR:  wrVal = a | b;
          FN_SLT: wrVal = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_JR: begin
            wr     = 1'b0;
            nextPc = a;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_LW: begin
        wr    = 1'b1;
        dst   = ins[20:16];
        wrVal = mMem[ea[8:2]];
      end
      OP_SW:  mMem[ea[8:2]] = b;
      OP_BEQ: if (a == b) nextPc = seq + {sImm[29:0], 2'b00};
      OP_J:   nextPc = {seq[31:28], ins[25:0], 2'b00};
      OP_JAL: begin
        nextPc = {seq[31:28], ins[25:0], 2'b00};
        wr     = 1'b1;
        dst    = LINK_REG;
        wrVal  = seq;
      end
      default: wr = 1'b0;
    endcase
    // register zero stays zero
    if (wr && dst != 5'd0) mRegs[dst] = wrVal;
    return wr;
  endfunction

  task automatic checkEq(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errCount++;
    end
  endtask

  //========================================================================
  // compare at mid cycle where outputs have settled
  //========================================================================
  always @(negedge clk) begin : compareStep
    word_t ins;
    word_t ea;
    word_t nPc;
    word_t val;
    logic  wr;
    logic  isLw;
    logic  isSw;
    if (running) begin
      ins  = imem[mPc[7:2]];
      isLw = (ins[31:26] == OP_LW);
      isSw = (ins[31:26] == OP_SW);
      ea   = mRegs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
      checkEq(instrAddr, mPc, "instrAddr");
      // strobe rules
      checkEq(cen, !(isLw || isSw), "cen");
      checkEq(wen, !isSw, "wen");
      checkEq(oen, !isLw, "oen");
      if (isLw || isSw) checkEq(memAddr, ea[8:2], "memAddr");
      if (isSw) checkEq(memWdata, mRegs[ins[20:16]], "memWdata");
      wr = refStep(ins, nPc, val);
      if (wr) checkEq(regWriteData, val, "regWriteData");
      mPc = nPc;
      execCount++;
    end
  end

  // reset asserted and ROM cleared
  task automatic beginTest;
    @(posedge clk);
    #1 rst = 1'b0;
    running = 1'b0;
    for (int i = 0; i < 64; i++) imem[i] = '0;
  endtask

  task automatic runProgram(input string name, input int steps);
    int errBefore;
    errBefore = errCount;
    fillDataMem();
    mPc = RESET_PC;
    for (int i = 0; i < 32; i++) mRegs[i] = '0;
    execCount = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b1;
    running = 1'b1;
    wait (execCount == steps);
    running = 1'b0;
    if (errCount == errBefore) begin
      passCount++;
      $display("test %s: %0d instructions ok", name, steps);
    end else begin
      failCount++;
      $display("test %s: %0d mismatches", name, errCount - errBefore);
    end
  endtask

  //========================================================================
  // test programs
  //========================================================================
  initial begin
    // alu ops with r9 holding the negated r1 for signed slt
    beginTest();
    imem[0]  = iType(OP_LW, 0, 1, 0);
    imem[1]  = iType(OP_LW, 0, 2, 4);
    imem[2]  = rType(3, 1, 2, FN_ADD);
    imem[3]  = rType(4, 1, 2, FN_SUB);
    imem[4]  = rType(5, 1, 2, FN_AND);
    imem[5]  = rType(6, 1, 2, FN_OR);
    imem[6]  = rType(7, 1, 2, FN_SLT);
    imem[7]  = rType(8, 2, 1, FN_SLT);
    imem[8]  = rType(9, 0, 1, FN_SUB);
    imem[9]  = rType(10, 9, 1, FN_SLT);
    imem[10] = rType(11, 1, 9, FN_SLT);
    runProgram("alu", 12);

    // store then load at same and different words
    beginTest();
    imem[0] = iType(OP_LW, 0, 1, 8);
    imem[1] = iType(OP_SW, 0, 1, 40);
    imem[2] = iType(OP_LW, 0, 2, 40);
    imem[3] = iType(OP_LW, 0, 3, 44);
    imem[4] = iType(OP_SW, 0, 3, 400);
    imem[5] = iType(OP_LW, 0, 4, 400);
    imem[6] = iType(OP_SW, 0, 2, 44);
    imem[7] = iType(OP_LW, 0, 5, 44);
    imem[8] = iType(OP_LW, 0, 6, 40);
    runProgram("memory", 9);

    // taken, not taken, forward and backward
    beginTest();
    imem[0]  = iType(OP_LW, 0, 1, 12);
    imem[1]  = iType(OP_LW, 0, 2, 12);
    imem[2]  = iType(OP_BEQ, 1, 2, 2);
    imem[3]  = rType(3, 1, 1, FN_ADD);
    imem[4]  = rType(4, 1, 1, FN_ADD);
    imem[5]  = iType(OP_LW, 0, 5, 16);
    imem[6]  = iType(OP_BEQ, 1, 5, 5);
    imem[7]  = iType(OP_BEQ, 7, 0, 2);
    imem[8]  = rType(8, 1, 2, FN_ADD);
    imem[9]  = iType(OP_BEQ, 0, 0, 3);
    imem[10] = rType(7, 1, 0, FN_ADD);
    imem[11] = iType(OP_BEQ, 0, 0, -4);
    imem[13] = rType(9, 1, 2, FN_OR);
    runProgram("branch", 12);

    // j, jal into a subroutine, jr back
    beginTest();
    imem[0]  = jType(OP_J, 16);
    imem[1]  = rType(6, 1, 1, FN_ADD);
    imem[4]  = jType(OP_JAL, 32);
    imem[5]  = iType(OP_LW, 0, 3, 24);
    imem[6]  = jType(OP_J, 40);
    imem[8]  = rType(4, 31, 0, FN_ADD);
    imem[9]  = rType(0, 31, 0, FN_JR);
    imem[10] = rType(5, 3, 4, FN_OR);
    runProgram("jump", 8);

    // writes to r0 and an unknown function code
    beginTest();
    imem[0] = iType(OP_LW, 0, 0, 0);
    imem[1] = iType(OP_LW, 0, 1, 4);
    imem[2] = rType(0, 1, 1, FN_ADD);
    imem[3] = rType(2, 0, 1, FN_ADD);
    imem[4] = rType(3, 1, 1, 6'b111111);
    imem[5] = rType(4, 3, 1, FN_OR);
    runProgram("zero", 7);

    $display("tests passed: %0d failed: %0d assertion failures: %0d",
             passCount, failCount, DUT.uAsserts.assertFails);
    if (errCount == 0 && DUT.uAsserts.assertFails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
